//--- hw/l1DcachePkg.sv
// geometry and type definitions shared by every L1 data cache module and its checker
`default_nettype none

package l1DcachePkg;

	// address and line geometry
	localparam int AddrWidth   = 32;
	localparam int LineBytes   = 16;
	localparam int LineWidth   = LineBytes * 8;
	localparam int ValWidth    = 64;
	localparam int OffsetWidth = $clog2(LineBytes);
	localparam int IndexWidth  = 6;
	localparam int NumLines    = 1 << IndexWidth;
	localparam int TagWidth    = AddrWidth - IndexWidth - OffsetWidth;

	// top nibble of a flush address that flushes the whole cache
	localparam logic [3:0] FlushAllRegion = 4'hF;

	// request opcodes
	// bit 4 store, bit 3 load, bit 2 zero-extend, bits 1:0 log2 of the size in bytes
	typedef enum logic [4:0] {
		Ready  = 5'b00000,
		Flush  = 5'b00100,
		LoadB  = 5'b01000,
		LoadH  = 5'b01001,
		LoadW  = 5'b01010,
		LoadD  = 5'b01011,
		LoadUB = 5'b01100,
		LoadUH = 5'b01101,
		LoadUW = 5'b01110,
		StoreB = 5'b10000,
		StoreH = 5'b10001,
		StoreW = 5'b10010,
		StoreD = 5'b10011
	} reqOpmT;

	// response to the CPU
	typedef enum logic [1:0] {
		RespReady = 2'b00,
		RespHold  = 2'b01,
		RespOk    = 2'b10
	} respOkT;

	// tile commands to memory
	typedef enum logic [1:0] {
		MemReady  = 2'b00,
		MemRdTile = 2'b01,
		MemWrTile = 2'b10
	} memOpmT;

	// memory status
	typedef enum logic [1:0] {
		MemIdle = 2'b00,
		MemHold = 2'b01,
		MemDone = 2'b10
	} memOkT;

	// miss sequencer states
	typedef enum logic [2:0] {
		Idle    = 3'd0,
		WbIssue = 3'd1,
		WbWait  = 3'd2,
		RdIssue = 3'd3,
		RdWait  = 3'd4,
		Resume  = 3'd5
	} missStateT;

endpackage

`default_nettype wire

//--- hw/dcacheTagStore.sv
// tag, dirty and flush-mask storage for the L1 data cache with a registered lookup
`timescale 1ns/100ps
`default_nettype none

module dcacheTagStore import l1DcachePkg::*;
(
	input wire logic                  clock,
	input wire logic                  reset,
	input wire logic [IndexWidth-1:0] rdIndex,
	input wire logic                  wrEn,
	input wire logic [IndexWidth-1:0] wrIndex,
	input wire logic [TagWidth-1:0]   wrTag,
	input wire logic                  wrDirty,
	input wire logic                  flushOne,
	input wire logic                  flushAll,
	input wire logic [IndexWidth-1:0] flushIndex,
	output logic [TagWidth-1:0]       rdTag,
	output logic                      rdDirty,
	output logic                      rdFlushed
);

	logic [TagWidth-1:0] tagArray [NumLines];
	logic [NumLines-1:0] dirtyBits;
	logic [NumLines-1:0] flushMask;
	logic [NumLines-1:0] nextDirty;
	logic [NumLines-1:0] nextMask;

	// flag state after this cycle's flush and write
	always_comb
	begin
		nextDirty = dirtyBits;
		nextMask  = flushMask;
		if (flushAll)
		begin
			nextMask = '1;
		end
		else if (flushOne)
		begin
			nextMask[flushIndex] = 1'b1;
		end
		// a written line is valid again
		if (wrEn)
		begin
			nextDirty[wrIndex] = wrDirty;
			nextMask[wrIndex]  = 1'b0;
		end
	end

	// flags are looked up from the next state, so a write or flush
	// in the same cycle is already visible to the lookup
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			dirtyBits <= '0;
			flushMask <= '1;
			rdDirty   <= 1'b0;
			rdFlushed <= 1'b1;
		end
		else
		begin
			dirtyBits <= nextDirty;
			flushMask <= nextMask;
			rdDirty   <= nextDirty[rdIndex];
			rdFlushed <= nextMask[rdIndex];
		end
	end

	// tag array with last-write bypass
	always_ff @(posedge clock)
	begin
		if (wrEn)
		begin
			tagArray[wrIndex] <= wrTag;
		end
		if (wrEn && (wrIndex == rdIndex))
		begin
			rdTag <= wrTag;
		end
		else
		begin
			rdTag <= tagArray[rdIndex];
		end
	end

endmodule

`default_nettype wire

//--- hw/dcacheDataStore.sv
// line data array of the L1 data cache with a registered read and last-write bypass
`timescale 1ns/100ps
`default_nettype none

module dcacheDataStore import l1DcachePkg::*;
(
	input wire logic                  clock,
	input wire logic [IndexWidth-1:0] rdIndex,
	input wire logic                  wrEn,
	input wire logic [IndexWidth-1:0] wrIndex,
	input wire logic [LineWidth-1:0]  wrLine,
	output logic [LineWidth-1:0]      rdLine
);

	// one 16-byte tile per line
	logic [LineWidth-1:0] lineArray [NumLines];
	logic                 bypassHit;

	// write landing on the line being read this cycle
	assign bypassHit = wrEn && (wrIndex == rdIndex);

	always_ff @(posedge clock)
	begin
		if (wrEn)
		begin
			lineArray[wrIndex] <= wrLine;
		end
	end

	// the array still holds the old line at this edge
	always_ff @(posedge clock)
	begin
		if (bypassHit)
		begin
			rdLine <= wrLine;
		end
		else
		begin
			rdLine <= lineArray[rdIndex];
		end
	end

endmodule

`default_nettype wire

//--- hw/dcacheLoadStoreAlign.sv
// extracts and extends load values from a cache line and merges store data into it
`timescale 1ns/100ps
`default_nettype none

module dcacheLoadStoreAlign import l1DcachePkg::*;
(
	input var reqOpmT                  opm,
	input wire logic [OffsetWidth-1:0] byteOffset,
	input wire logic [LineWidth-1:0]   line,
	input wire logic [ValWidth-1:0]    storeVal,
	output logic [ValWidth-1:0]        loadVal,
	output logic [LineWidth-1:0]       mergedLine
);

	logic [OffsetWidth+2:0] bitShift;
	logic [LineWidth-1:0]   lineShifted;
	logic [ValWidth-1:0]    raw;
	logic [ValWidth-1:0]    sizeMask;
	logic [LineWidth-1:0]   laneMask;
	logic [LineWidth-1:0]   storeLane;

	assign bitShift    = {byteOffset, 3'b000};
	assign lineShifted = line >> bitShift;

	// accesses are aligned so the value never leaves the line
	assign raw = lineShifted[ValWidth-1:0];

	// size and signedness straight from the opcode bits
	always_comb
	begin
		case (opm[2:0])
			3'b000:
				loadVal = {{(ValWidth-8){raw[7]}}, raw[7:0]};
			3'b001:
				loadVal = {{(ValWidth-16){raw[15]}}, raw[15:0]};
			3'b010:
				loadVal = {{(ValWidth-32){raw[31]}}, raw[31:0]};
			3'b100:
				loadVal = {{(ValWidth-8){1'b0}}, raw[7:0]};
			3'b101:
				loadVal = {{(ValWidth-16){1'b0}}, raw[15:0]};
			3'b110:
				loadVal = {{(ValWidth-32){1'b0}}, raw[31:0]};
			default:
				loadVal = raw;
		endcase
	end

	// bytes touched by a store of this size
	always_comb
	begin
		case (opm[1:0])
			2'b00:
				sizeMask = {{(ValWidth-8){1'b0}}, 8'hFF};
			2'b01:
				sizeMask = {{(ValWidth-16){1'b0}}, 16'hFFFF};
			2'b10:
				sizeMask = {{(ValWidth-32){1'b0}}, 32'hFFFF_FFFF};
			default:
				sizeMask = '1;
		endcase
	end

	// move mask and data to the byte offset, then splice
	assign laneMask   = {{(LineWidth-ValWidth){1'b0}}, sizeMask} << bitShift;
	assign storeLane  = {{(LineWidth-ValWidth){1'b0}}, storeVal & sizeMask} << bitShift;
	assign mergedLine = (line & ~laneMask) | storeLane;

endmodule

`default_nettype wire

//--- hw/dcacheMissFsm.sv
// miss sequencer of the L1 data cache, runs victim writeback and tile refill over memory
`timescale 1ns/100ps
`default_nettype none

module dcacheMissFsm import l1DcachePkg::*;
(
	input wire logic                 clock,
	input wire logic                 reset,
	input wire logic                 missStart,
	input wire logic [AddrWidth-1:0] reqAddr,
	input wire logic [TagWidth-1:0]  victimTag,
	input wire logic                 victimDirty,
	input wire logic [LineWidth-1:0] victimLine,
	input var memOkT                 memOk,
	input wire logic [LineWidth-1:0] memDataIn,
	output memOpmT                   memOpm,
	output logic [AddrWidth-1:0]     memAddr,
	output logic [LineWidth-1:0]     memDataOut,
	output logic                     fillWrEn,
	output logic [LineWidth-1:0]     fillLine,
	output logic                     fillBusy
);

	missStateT            state;
	logic [AddrWidth-1:0] wbAddr;
	logic [AddrWidth-1:0] fillAddr;
	logic                 memFree;

	// a new tile request may only start once memory is back to idle
	assign memFree = (memOk == MemIdle);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state  <= Idle;
			memOpm <= MemReady;
		end
		else
		begin
			case (state)
				Idle:
				begin
					if (missStart)
					begin
						state <= victimDirty ? WbIssue : RdIssue;
					end
				end
				WbIssue:
				begin
					if (memFree)
					begin
						memOpm <= MemWrTile;
						state  <= WbWait;
					end
				end
				WbWait:
				begin
					if (memOk == MemDone)
					begin
						memOpm <= MemReady;
						state  <= RdIssue;
					end
				end
				RdIssue:
				begin
					if (memFree)
					begin
						memOpm <= MemRdTile;
						state  <= RdWait;
					end
				end
				RdWait:
				begin
					if (memOk == MemDone)
					begin
						memOpm <= MemReady;
						state  <= Resume;
					end
				end
				// one cycle for the arrays to be read back
				Resume:
				begin
					state <= Idle;
				end
				default:
				begin
					state  <= Idle;
					memOpm <= MemReady;
				end
			endcase
		end
	end

	// victim and request captured at the start of the miss
	always_ff @(posedge clock)
	begin
		if (missStart && (state == Idle))
		begin
			wbAddr     <= {victimTag, reqAddr[OffsetWidth +: IndexWidth], {OffsetWidth{1'b0}}};
			fillAddr   <= {reqAddr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
			memDataOut <= victimLine;
		end
		if ((state == WbIssue) && memFree)
		begin
			memAddr <= wbAddr;
		end
		else if ((state == RdIssue) && memFree)
		begin
			memAddr <= fillAddr;
		end
	end

	// refill lands in the cycle of the read completion
	assign fillWrEn = (state == RdWait) && (memOk == MemDone);
	assign fillLine = memDataIn;
	assign fillBusy = (state != Idle);

endmodule

`default_nettype wire

//--- hw/l1Dcache.sv
// top level of the direct-mapped write-back L1 data cache, instantiated by the CPU core
`timescale 1ns/100ps
`default_nettype none

module l1Dcache import l1DcachePkg::*;
(
	input wire logic                 clock,
	input wire logic                 reset,
	input var reqOpmT                reqOpm,
	input wire logic [AddrWidth-1:0] reqAddr,
	input wire logic [ValWidth-1:0]  reqVal,
	input var memOkT                 memOk,
	input wire logic [LineWidth-1:0] memDataIn,
	output respOkT                   respOk,
	output logic [ValWidth-1:0]      loadVal,
	output memOpmT                   memOpm,
	output logic [AddrWidth-1:0]     memAddr,
	output logic [LineWidth-1:0]     memDataOut
);

	reqOpmT                opmB;
	logic [AddrWidth-1:0]  addrB;
	logic [ValWidth-1:0]   valB;
	logic [IndexWidth-1:0] idxB;
	logic [TagWidth-1:0]   tagB;
	logic [TagWidth-1:0]   rdTag;
	logic                  rdDirty;
	logic                  rdFlushed;
	logic [LineWidth-1:0]  rdLine;
	logic [LineWidth-1:0]  mergedLine;
	logic [LineWidth-1:0]  fillLine;
	logic [LineWidth-1:0]  wrLine;
	logic                  isAccess;
	logic                  isStore;
	logic                  isFlush;
	logic                  miss;
	logic                  hold;
	logic                  missStart;
	logic                  storeCommit;
	logic                  wrEn;
	logic                  flushAllReq;
	logic                  fillWrEn;
	logic                  fillBusy;

	// stage A, the request is registered while the previous one is looked up
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			opmB <= Ready;
		end
		else
		begin
			opmB <= reqOpm;
		end
	end

	always_ff @(posedge clock)
	begin
		addrB <= reqAddr;
		valB  <= reqVal;
	end

	// stage B, hit decision
	assign idxB     = addrB[OffsetWidth +: IndexWidth];
	assign tagB     = addrB[AddrWidth-1 -: TagWidth];
	assign isStore  = opmB[4];
	assign isAccess = opmB[4] || opmB[3];
	assign isFlush  = (opmB == Flush);
	assign miss     = rdFlushed || (rdTag != tagB);

	// hold until the refill sequence has fully finished
	assign hold        = isAccess && (miss || fillBusy);
	assign missStart   = isAccess && miss && !fillBusy;
	assign storeCommit = isStore && !hold;
	assign flushAllReq = isFlush && (addrB[AddrWidth-1 -: 4] == FlushAllRegion);

	always_comb
	begin
		if (opmB == Ready)
			respOk = RespReady;
		else if (hold)
			respOk = RespHold;
		else
			respOk = RespOk;
	end

	// refill installs a clean line, a store hit a dirty one
	assign wrEn   = storeCommit || fillWrEn;
	assign wrLine = fillWrEn ? fillLine : mergedLine;

	dcacheTagStore u_tagStore (
		.clock      (clock),
		.reset      (reset),
		.rdIndex    (reqAddr[OffsetWidth +: IndexWidth]),
		.wrEn       (wrEn),
		.wrIndex    (idxB),
		.wrTag      (tagB),
		.wrDirty    (storeCommit),
		.flushOne   (isFlush && !flushAllReq),
		.flushAll   (flushAllReq),
		.flushIndex (idxB),
		.rdTag      (rdTag),
		.rdDirty    (rdDirty),
		.rdFlushed  (rdFlushed)
	);

	dcacheDataStore u_dataStore (
		.clock   (clock),
		.rdIndex (reqAddr[OffsetWidth +: IndexWidth]),
		.wrEn    (wrEn),
		.wrIndex (idxB),
		.wrLine  (wrLine),
		.rdLine  (rdLine)
	);

	dcacheLoadStoreAlign u_align (
		.opm        (opmB),
		.byteOffset (addrB[OffsetWidth-1:0]),
		.line       (rdLine),
		.storeVal   (valB),
		.loadVal    (loadVal),
		.mergedLine (mergedLine)
	);

	dcacheMissFsm u_missFsm (
		.clock       (clock),
		.reset       (reset),
		.missStart   (missStart),
		.reqAddr     (addrB),
		.victimTag   (rdTag),
		.victimDirty (rdDirty),
		.victimLine  (rdLine),
		.memOk       (memOk),
		.memDataIn   (memDataIn),
		.memOpm      (memOpm),
		.memAddr     (memAddr),
		.memDataOut  (memDataOut),
		.fillWrEn    (fillWrEn),
		.fillLine    (fillLine),
		.fillBusy    (fillBusy)
	);

endmodule

`default_nettype wire

//--- sim/l1DcacheCheck_assert.sv
// checker bound into the L1 data cache, compares its responses with a shadow memory
`timescale 1ns/100ps
`default_nettype none

module l1DcacheCheck import l1DcachePkg::*;
(
	input wire logic                 clock,
	input wire logic                 reset,
	input var reqOpmT                cpuOpm,
	input var reqOpmT                opm,
	input wire logic [AddrWidth-1:0] addr,
	input wire logic [ValWidth-1:0]  val,
	input var respOkT                respOk,
	input wire logic [ValWidth-1:0]  loadVal,
	input var memOpmT                memOpm,
	input wire logic [AddrWidth-1:0] memAddr,
	input wire logic [LineWidth-1:0] memDataOut,
	input var memOkT                 memOk
);

	int                    errorCount = 0;
	// covers the 4 KB window the testbench works in
	logic [7:0]            shadow [4096];
	logic [NumLines-1:0]   needRefill;
	logic                  started;
	logic                  sawHold;
	logic                  refillSeen;
	logic                  wbPending;
	logic                  isLoad;
	logic                  isAccess;
	int                    storeBytes;
	logic [ValWidth-1:0]   rawVal;
	logic [ValWidth-1:0]   expLoad;
	logic [LineWidth-1:0]  shadowTile;
	logic [IndexWidth-1:0] reqIndex;

	function automatic logic [7:0] patternByte(input logic [AddrWidth-1:0] a);
		return a[7:0] ^ (a[15:8] * 8'd37) ^ (a[23:16] * 8'd11) ^ a[31:24];
	endfunction

	task automatic reportFailure(input string what);
		errorCount++;
		$error("[FAIL] %0t %s", $time, what);
	endtask

	assign isLoad   = opm inside {LoadB, LoadH, LoadW, LoadD, LoadUB, LoadUH, LoadUW};
	assign isAccess = isLoad || (storeBytes != 0);
	assign reqIndex = addr[OffsetWidth +: IndexWidth];

	always_comb
	begin
		case (opm)
			StoreB:  storeBytes = 1;
			StoreH:  storeBytes = 2;
			StoreW:  storeBytes = 4;
			StoreD:  storeBytes = 8;
			default: storeBytes = 0;
		endcase
	end

	// expected load, little endian from the shadow
	always_comb
	begin
		for (int k = 0; k < 8; k++)
			rawVal[k*8 +: 8] = shadow[addr[11:0] + 12'(k)];
		case (opm)
			LoadB:   expLoad = {{56{rawVal[7]}}, rawVal[7:0]};
			LoadH:   expLoad = {{48{rawVal[15]}}, rawVal[15:0]};
			LoadW:   expLoad = {{32{rawVal[31]}}, rawVal[31:0]};
			LoadUB:  expLoad = {56'd0, rawVal[7:0]};
			LoadUH:  expLoad = {48'd0, rawVal[15:0]};
			LoadUW:  expLoad = {32'd0, rawVal[31:0]};
			default: expLoad = rawVal;
		endcase
	end

	// shadow contents of the tile on the memory port
	always_comb
	begin
		for (int k = 0; k < LineBytes; k++)
			shadowTile[k*8 +: 8] = shadow[{memAddr[11:4], 4'(k)}];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < 4096; i++)
				shadow[i] <= patternByte(32'(i));
			needRefill <= '1;
			started    <= 1'b0;
			sawHold    <= 1'b0;
			refillSeen <= 1'b0;
			wbPending  <= 1'b0;
		end
		else
		begin
			// first request seen on the CPU port
			if (cpuOpm != Ready)
				started <= 1'b1;
			if (respOk == RespHold)
				sawHold <= 1'b1;
			if ((memOpm == MemWrTile) && (memOk == MemDone))
				wbPending <= 1'b1;
			if (memOpm == MemRdTile)
				wbPending <= 1'b0;
			if ((memOpm == MemRdTile) && (memOk == MemDone))
			begin
				needRefill[memAddr[OffsetWidth +: IndexWidth]] <= 1'b0;
				if (memAddr[AddrWidth-1:OffsetWidth] == addr[AddrWidth-1:OffsetWidth])
					refillSeen <= 1'b1;
			end
			if (respOk == RespOk)
			begin
				sawHold    <= 1'b0;
				refillSeen <= 1'b0;
				for (int k = 0; k < 8; k++)
				begin
					if (k < storeBytes)
						shadow[addr[11:0] + 12'(k)] <= val[k*8 +: 8];
				end
				if ((opm == Flush) && (addr[AddrWidth-1 -: 4] == FlushAllRegion))
					needRefill <= '1;
				else if (opm == Flush)
					needRefill[reqIndex] <= 1'b1;
			end
		end
	end

	a_idleAfterReset: assert property (@(posedge clock) disable iff (reset)
		!started |-> (respOk == RespReady) && (memOpm == MemReady))
		else reportFailure("cache not idle after reset");

	a_loadValue: assert property (@(posedge clock) disable iff (reset)
		(respOk == RespOk) && isLoad |-> loadVal == expLoad)
		else reportFailure("load value differs from shadow memory");

	a_writebackData: assert property (@(posedge clock) disable iff (reset)
		memOpm == MemWrTile |-> memDataOut == shadowTile)
		else reportFailure("writeback tile differs from shadow memory");

	a_writebackOrder: assert property (@(posedge clock) disable iff (reset)
		(memOpm == MemWrTile) || (respOk == RespOk) |-> !wbPending)
		else reportFailure("writeback not followed by a tile read");

	a_flushRefill: assert property (@(posedge clock) disable iff (reset)
		(respOk == RespOk) && isAccess |-> !needRefill[reqIndex])
		else reportFailure("flushed line answered without a refill");

	a_memStable: assert property (@(posedge clock) disable iff (reset)
		(memOpm != MemReady) && (memOk != MemDone) |=> $stable(memOpm) && $stable(memAddr))
		else reportFailure("memory request changed before completion");

	a_memIdleGap: assert property (@(posedge clock) disable iff (reset)
		(memOpm == MemReady) && (memOk != MemIdle) |=> memOpm == MemReady)
		else reportFailure("tile request issued before memory returned to idle");

	a_holdRefill: assert property (@(posedge clock) disable iff (reset)
		(respOk == RespOk) && sawHold |-> refillSeen)
		else reportFailure("held request completed without a refill of its line");

endmodule

`default_nettype wire

//--- sim/l1DcacheTb.sv
// testbench for the L1 data cache, runs directed and random requests against a memory model
`timescale 1ns/100ps
`default_nettype none

module l1DcacheTb import l1DcachePkg::*; ();

	localparam int DirectedOps    = 27;
	localparam int RandomOps      = 300;
	localparam int WatchdogCycles = (DirectedOps + RandomOps) * 400 + 1000;
	localparam int TestBytes      = 4096;

	logic                 clock;
	logic                 reset;
	reqOpmT               reqOpm;
	logic [AddrWidth-1:0] reqAddr;
	logic [ValWidth-1:0]  reqVal;
	memOkT                memOk;
	logic [LineWidth-1:0] memDataIn;
	respOkT               respOk;
	logic [ValWidth-1:0]  loadVal;
	memOpmT               memOpm;
	logic [AddrWidth-1:0] memAddr;
	logic [LineWidth-1:0] memDataOut;
	integer               seed;
	// tiles written back by the cache, all others follow the pattern
	logic [LineWidth-1:0] memLines [logic [AddrWidth-OffsetWidth-1:0]];
	reqOpmT               opTable [12] = '{LoadB, LoadH, LoadW, LoadD, LoadUB, LoadUH, LoadUW,
		StoreB, StoreH, StoreW, StoreD, Flush};

	l1Dcache u_l1Dcache (
		.clock      (clock),
		.reset      (reset),
		.reqOpm     (reqOpm),
		.reqAddr    (reqAddr),
		.reqVal     (reqVal),
		.memOk      (memOk),
		.memDataIn  (memDataIn),
		.respOk     (respOk),
		.loadVal    (loadVal),
		.memOpm     (memOpm),
		.memAddr    (memAddr),
		.memDataOut (memDataOut)
	);

	bind l1Dcache l1DcacheCheck u_check (
		.clock      (clock),
		.reset      (reset),
		.cpuOpm     (reqOpm),
		.opm        (opmB),
		.addr       (addrB),
		.val        (valB),
		.respOk     (respOk),
		.loadVal    (loadVal),
		.memOpm     (memOpm),
		.memAddr    (memAddr),
		.memDataOut (memDataOut),
		.memOk      (memOk)
	);

	function automatic logic [7:0] patternByte(input logic [AddrWidth-1:0] a);
		return a[7:0] ^ (a[15:8] * 8'd37) ^ (a[23:16] * 8'd11) ^ a[31:24];
	endfunction

	function automatic logic [LineWidth-1:0] tileAt(input logic [AddrWidth-1:0] a);
		logic [LineWidth-1:0] tile;
		if (memLines.exists(a[AddrWidth-1:OffsetWidth]))
			return memLines[a[AddrWidth-1:OffsetWidth]];
		for (int k = 0; k < LineBytes; k++)
			tile[k*8 +: 8] = patternByte({a[AddrWidth-1:OffsetWidth], 4'(k)});
		return tile;
	endfunction

	function automatic int sizeOf(input reqOpmT op);
		case (op)
			LoadH, LoadUH, StoreH: return 2;
			LoadW, LoadUW, StoreW: return 4;
			LoadD, StoreD:         return 8;
			default:               return 1;
		endcase
	endfunction

	// present one request and wait for its Ok, inputs stay put while on hold
	task automatic request(input reqOpmT op, input logic [AddrWidth-1:0] addr,
		input logic [ValWidth-1:0] val);
		reqOpm  = op;
		reqAddr = addr;
		reqVal  = val;
		@(negedge clock);
		while (respOk != RespOk)
			@(negedge clock);
	endtask

	// answer one tile command after a few busy cycles
	task automatic serveTile();
		memOpmT               op;
		logic [AddrWidth-1:0] a;
		int                   holds;
		int                   busyAfter;
		op        = memOpm;
		a         = memAddr;
		holds     = 1 + ($unsigned($random(seed)) % 4);
		busyAfter = $unsigned($random(seed)) % 3;
		repeat (holds)
		begin
			memOk = MemHold;
			@(negedge clock);
		end
		if (op == MemWrTile)
			memLines[a[AddrWidth-1:OffsetWidth]] = memDataOut;
		else
			memDataIn = tileAt(a);
		memOk = MemDone;
		@(negedge clock);
		// memory may stay busy for a while after completing
		repeat (busyAfter)
		begin
			memOk = MemHold;
			@(negedge clock);
		end
		memOk = MemIdle;
	endtask

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// memory model
	initial
	begin
		memOk     = MemIdle;
		memDataIn = '0;
		forever
		begin
			@(negedge clock);
			if (memOpm != MemReady)
				serveTile();
		end
	end

	initial
	begin
		repeat (WatchdogCycles) @(posedge clock);
		$display("watchdog expired after %0d cycles with requests still open", WatchdogCycles);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		reqOpmT               op;
		logic [AddrWidth-1:0] addr;
		int                   errors;
		seed    = 32'heedb;
		reset   = 1'b1;
		reqOpm  = Ready;
		reqAddr = '0;
		reqVal  = '0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		repeat (4) @(negedge clock);

		// store then loads back to back on one line
		request(StoreD, 32'h100, 64'h8877_6655_C433_2211);
		request(LoadD, 32'h100, '0);
		request(LoadW, 32'h104, '0);
		request(LoadUB, 32'h107, '0);
		request(StoreB, 32'h105, 64'hF0);
		request(LoadH, 32'h104, '0);
		request(LoadUH, 32'h104, '0);
		// dirty line evicted by another tag, then read back from memory
		request(LoadW, 32'h500, '0);
		request(LoadD, 32'h108, '0);
		// flushed dirty line
		request(StoreW, 32'h200, 64'h1234_5678);
		request(Flush, 32'h200, '0);
		request(LoadUW, 32'h200, '0);
		// flush of every line
		request(LoadB, 32'h300, '0);
		request(StoreH, 32'h342, 64'hBEEF);
		request(LoadUB, 32'h3F1, '0);
		request(Flush, 32'hF000_0000, '0);
		request(LoadH, 32'h302, '0);
		request(LoadUH, 32'h342, '0);
		request(LoadB, 32'h3F1, '0);
		// all load sizes on bytes with the top bit set and clear
		request(StoreD, 32'h7F8, 64'h80FF_7F01_8000_FF7F);
		for (int k = 0; k < 7; k++)
			request(opTable[k], 32'h7F8, '0);
		reqOpm = Ready;
		repeat (3) @(negedge clock);

		for (int n = 0; n < RandomOps; n++)
		begin
			op   = opTable[$unsigned($random(seed)) % 12];
			addr = $unsigned($random(seed)) % TestBytes;
			addr = addr & ~(sizeOf(op) - 1);
			if ((op == Flush) && (($unsigned($random(seed)) % 8) == 0))
				addr = 32'hF000_0000;
			request(op, addr, {$random(seed), $random(seed)});
		end
		reqOpm = Ready;
		repeat (8) @(negedge clock);

		errors = u_l1Dcache.u_check.errorCount;
		$display("run finished with %0d errors", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hw/l1DcachePkg.sv
hw/dcacheTagStore.sv
hw/dcacheDataStore.sv
hw/dcacheLoadStoreAlign.sv
hw/dcacheMissFsm.sv
hw/l1Dcache.sv
sim/l1DcacheCheck_assert.sv
sim/l1DcacheTb.sv
